// ==== source/mazePkg.sv ====
package mazePkg;

    // Maze states that also serve as the drive command
    typedef enum logic [4:0] {
        Idle        = 5'd0,
        Start       = 5'd1,
        Count       = 5'd2,
        Straight    = 5'd3,
        Choose      = 5'd4,
        TurnLeft    = 5'd5,
        TurnRight   = 5'd6,
        Back        = 5'd7,
        LittleLeft  = 5'd8,
        LittleRight = 5'd9,
        Finish      = 5'd29,
        Stop        = 5'd30,
        Error       = 5'd31
    } navState_t;

    // Left, middle, right sensor from MSB to LSB
    typedef logic [2:0] roadCode_t;
    typedef logic [19:0] distance_t;
    typedef logic [15:0] ledWord_t;

    typedef struct packed {
        logic cpChoose;
        logic cpStraight;
        logic cpLeftExit;
        logic cpRightExit;
        logic cpLeftSplit;
    } checkpoints_t;

    typedef struct packed {
        logic       countDone;
        logic [1:0] countStep;
        logic       countFlash;
        logic       resumeNow;
        logic       backFlash;
        logic [2:0] chooseLamp;
    } timerStatus_t;

    localparam roadCode_t roadNone        = 3'b000;
    localparam roadCode_t roadRight       = 3'b011;
    localparam roadCode_t roadStraight    = 3'b010;
    localparam roadCode_t roadRightSlight = 3'b001;
    localparam roadCode_t roadLeft        = 3'b110;
    localparam roadCode_t roadSplit       = 3'b101;
    localparam roadCode_t roadLeftSlight  = 3'b100;
    localparam roadCode_t roadFull        = 3'b111;

    // Short timer lengths in clock cycles
    localparam int countStepTicks = 8;
    localparam int countSteps     = 3;
    localparam int stopTicks      = 12;
    localparam int flashTicks     = 4;
    localparam int lampTicks      = 6;
    localparam int obstacleLimit  = 2;
    localparam int rightCrossings = 2;

endpackage

// ==== source/navFsm.sv ====
`timescale 1ns/10ps

module navFsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  mazePkg::roadCode_t    road,
    input  mazePkg::distance_t    distance,
    input  mazePkg::checkpoints_t checkpoints,
    input  logic                  turnDone,
    input  mazePkg::timerStatus_t timers,
    output mazePkg::navState_t    state,
    output logic                  obstacleNear,
    output logic                  startDone
);

    mazePkg::navState_t nextState;
    mazePkg::navState_t storedState;
    mazePkg::navState_t storeNext;
    logic               pop;
    logic               popNext;
    logic               advance;

    assign obstacleNear = distance < mazePkg::obstacleLimit;

    // Normal rules apply only when enabled and the path is clear
    assign advance = enable && !obstacleNear;

    // One pulse on the countdown exit into Straight
    assign startDone = advance && (state == mazePkg::Count) && timers.countDone;

    always_comb begin
        nextState = state;
        storeNext = storedState;
        popNext   = pop;
        case (state)
            mazePkg::Idle: begin
                nextState = mazePkg::Start;
            end
            mazePkg::Start: begin
                if (road == mazePkg::roadStraight) begin
                    nextState = mazePkg::Count;
                end
            end
            mazePkg::Count: begin
                if (timers.countDone) begin
                    nextState = mazePkg::Straight;
                end
            end
            mazePkg::Straight, mazePkg::LittleLeft, mazePkg::LittleRight: begin
                case (road)
                    mazePkg::roadNone: begin
                        // Line lost so pause and then back up
                        nextState = mazePkg::Stop;
                        storeNext = mazePkg::Back;
                    end
                    mazePkg::roadFull: begin
                        nextState = checkpoints.cpStraight ? mazePkg::Choose
                                                           : mazePkg::Straight;
                    end
                    mazePkg::roadRight, mazePkg::roadRightSlight: begin
                        nextState = mazePkg::LittleRight;
                    end
                    mazePkg::roadLeft, mazePkg::roadLeftSlight: begin
                        nextState = mazePkg::LittleLeft;
                    end
                    default: begin
                        nextState = mazePkg::Straight;
                    end
                endcase
            end
            mazePkg::Choose: begin
                if (road == mazePkg::roadSplit) begin
                    nextState = mazePkg::Stop;
                    storeNext = mazePkg::TurnLeft;
                end else if (road == mazePkg::roadFull && checkpoints.cpChoose) begin
                    nextState = mazePkg::Straight;
                end
            end
            mazePkg::TurnLeft: begin
                if (road == mazePkg::roadSplit && checkpoints.cpLeftSplit) begin
                    nextState = mazePkg::Stop;
                    storeNext = mazePkg::TurnRight;
                end else if (road == mazePkg::roadFull && checkpoints.cpLeftExit) begin
                    nextState = mazePkg::Stop;
                    storeNext = mazePkg::Straight;
                end
            end
            mazePkg::TurnRight: begin
                if (road == mazePkg::roadSplit && turnDone) begin
                    nextState = mazePkg::Error;
                end else if (road == mazePkg::roadFull && checkpoints.cpRightExit
                             && turnDone) begin
                    nextState = mazePkg::Stop;
                    storeNext = mazePkg::Straight;
                end
            end
            mazePkg::Back: begin
                if (road == mazePkg::roadFull) begin
                    nextState = mazePkg::Stop;
                    // First dead end tries left and later ones try right
                    if (!pop) begin
                        storeNext = mazePkg::TurnLeft;
                        popNext   = 1'b1;
                    end else begin
                        storeNext = mazePkg::TurnRight;
                    end
                end
            end
            mazePkg::Stop: begin
                if (timers.resumeNow) begin
                    nextState = storedState;
                end
            end
            mazePkg::Finish, mazePkg::Error: begin
                // Held until enable drops
                nextState = state;
            end
            default: begin
                nextState = mazePkg::Idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= mazePkg::Idle;
            storedState <= mazePkg::Idle;
            pop         <= 1'b0;
        end else if (!enable) begin
            state <= mazePkg::Idle;
        end else if (obstacleNear) begin
            state <= mazePkg::Finish;
        end else begin
            state       <= nextState;
            storedState <= storeNext;
            pop         <= popNext;
        end
    end

    stateLegal: assert property (@(posedge clk) disable iff (rst)
        state inside {mazePkg::Idle, mazePkg::Start, mazePkg::Count, mazePkg::Straight,
                      mazePkg::Choose, mazePkg::TurnLeft, mazePkg::TurnRight, mazePkg::Back,
                      mazePkg::LittleLeft, mazePkg::LittleRight, mazePkg::Finish,
                      mazePkg::Stop, mazePkg::Error});

    obstacleFinish: assert property (@(posedge clk) disable iff (rst)
        enable && obstacleNear |=> state == mazePkg::Finish);

endmodule

// ==== source/checkpointTracker.sv ====
`timescale 1ns/10ps

module checkpointTracker (
    input  logic                  clk,
    input  logic                  rst,
    input  mazePkg::navState_t    state,
    input  mazePkg::roadCode_t    road,
    input  logic                  startDone,
    output mazePkg::checkpoints_t checkpoints
);

    logic inStraight;
    logic inChoose;
    logic inLeft;
    logic inRight;
    logic onFull;

    assign inStraight = (state == mazePkg::Straight) || (state == mazePkg::LittleLeft)
                     || (state == mazePkg::LittleRight);
    assign inChoose   = state == mazePkg::Choose;
    assign inLeft     = state == mazePkg::TurnLeft;
    assign inRight    = state == mazePkg::TurnRight;
    assign onFull     = road == mazePkg::roadFull;

    // A flag arms once the sensor has seen something other than its exit code
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            checkpoints <= '0;
        end else begin
            if (inChoose && !onFull) begin
                checkpoints.cpChoose <= 1'b1;
            end else if (!inChoose) begin
                checkpoints.cpChoose <= 1'b0;
            end

            // Leaving the countdown also arms the junction test
            if ((inStraight && !onFull) || startDone) begin
                checkpoints.cpStraight <= 1'b1;
            end else if (!inStraight) begin
                checkpoints.cpStraight <= 1'b0;
            end

            if (inLeft && !onFull) begin
                checkpoints.cpLeftExit <= 1'b1;
            end else if (!inLeft) begin
                checkpoints.cpLeftExit <= 1'b0;
            end

            if (inLeft && road != mazePkg::roadSplit) begin
                checkpoints.cpLeftSplit <= 1'b1;
            end else if (!inLeft) begin
                checkpoints.cpLeftSplit <= 1'b0;
            end

            if (inRight && !onFull) begin
                checkpoints.cpRightExit <= 1'b1;
            end else if (!inRight) begin
                checkpoints.cpRightExit <= 1'b0;
            end
        end
    end

    chooseOnlyInChoose: assert property (@(posedge clk) disable iff (rst)
        checkpoints.cpChoose |-> $past(state) == mazePkg::Choose);

endmodule

// ==== source/phaseTimer.sv ====
`timescale 1ns/10ps

module phaseTimer (
    input  logic                  clk,
    input  logic                  rst,
    input  mazePkg::navState_t    state,
    output mazePkg::timerStatus_t timers
);

    logic [$clog2(mazePkg::countStepTicks)-1:0] stepTick;
    logic [1:0]                                 stepCount;
    logic [$clog2(mazePkg::stopTicks)-1:0]      pauseCount;
    logic [$clog2(mazePkg::flashTicks)-1:0]     flashCount;
    logic                                       flashPhase;
    logic [$clog2(mazePkg::lampTicks)-1:0]      lampCount;
    logic [2:0]                                 lamp;
    logic                                       inCount;
    logic                                       inBack;
    logic                                       stepEnd;
    logic                                       countEnd;
    logic                                       pauseEnd;

    assign inCount  = state == mazePkg::Count;
    assign inBack   = state == mazePkg::Back;
    assign stepEnd  = stepTick == mazePkg::countStepTicks - 1;
    assign countEnd = inCount && stepEnd && stepCount == mazePkg::countSteps - 1;
    assign pauseEnd = (state == mazePkg::Stop) && pauseCount == mazePkg::stopTicks - 1;

    // Countdown steps, restarted on every entry into Count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stepTick  <= '0;
            stepCount <= '0;
        end else if (!inCount || countEnd) begin
            stepTick  <= '0;
            stepCount <= '0;
        end else if (stepEnd) begin
            stepTick  <= '0;
            stepCount <= stepCount + 1'b1;
        end else begin
            stepTick <= stepTick + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pauseCount <= '0;
        end else if (state != mazePkg::Stop || pauseEnd) begin
            pauseCount <= '0;
        end else begin
            pauseCount <= pauseCount + 1'b1;
        end
    end

    // Count and Back never overlap so they share one flash divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flashCount <= '0;
            flashPhase <= 1'b0;
        end else if (!(inCount || inBack)) begin
            flashCount <= '0;
            flashPhase <= 1'b0;
        end else if (flashCount == mazePkg::flashTicks - 1) begin
            flashCount <= '0;
            flashPhase <= ~flashPhase;
        end else begin
            flashCount <= flashCount + 1'b1;
        end
    end

    // Junction lamp walks one position per lampTicks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCount <= '0;
            lamp      <= 3'b001;
        end else if (state != mazePkg::Choose) begin
            lampCount <= '0;
            lamp      <= 3'b001;
        end else if (lampCount == mazePkg::lampTicks - 1) begin
            lampCount <= '0;
            lamp      <= {lamp[1:0], lamp[2]};
        end else begin
            lampCount <= lampCount + 1'b1;
        end
    end

    assign timers.countDone  = countEnd;
    assign timers.countStep  = stepCount;
    assign timers.countFlash = flashPhase && inCount;
    assign timers.resumeNow  = pauseEnd;
    assign timers.backFlash  = flashPhase && inBack;
    assign timers.chooseLamp = lamp;

endmodule

// ==== source/turnCounter.sv ====
`timescale 1ns/10ps

module turnCounter (
    input  logic               clk,
    input  logic               rst,
    input  mazePkg::navState_t state,
    input  mazePkg::roadCode_t road,
    input  logic               cpRightExit,
    output logic               turnDone,
    output logic [1:0]         crossings
);

    logic inRight;
    logic fullNow;
    logic fullPrev;
    logic fullEdge;

    assign inRight  = state == mazePkg::TurnRight;
    assign fullNow  = inRight && (road == mazePkg::roadFull);
    assign fullEdge = fullNow && !fullPrev;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fullPrev  <= 1'b0;
            crossings <= '0;
        end else begin
            fullPrev <= fullNow;
            if (!inRight) begin
                crossings <= '0;
            end else if (cpRightExit && fullEdge && crossings != 2'b11) begin
                // Saturates so a long turn cannot wrap back to zero
                crossings <= crossings + 1'b1;
            end
        end
    end

    assign turnDone = crossings >= mazePkg::rightCrossings;

endmodule

// ==== source/statusLeds.sv ====
`timescale 1ns/10ps

module statusLeds (
    input  mazePkg::navState_t    state,
    input  mazePkg::roadCode_t    road,
    input  logic                  obstacleNear,
    input  mazePkg::timerStatus_t timers,
    output mazePkg::ledWord_t     led
);

    logic [4:0] stateField;
    logic [5:0] activity;

    always_comb begin
        case (state)
            mazePkg::Idle:      stateField = 5'b00000;
            mazePkg::Start:     stateField = 5'b00001;
            mazePkg::Count:     stateField = 5'b00010;
            mazePkg::Straight:  stateField = 5'b01000;
            mazePkg::Choose:    stateField = {timers.chooseLamp, 2'b00};
            mazePkg::TurnLeft:  stateField = 5'b10000;
            mazePkg::TurnRight: stateField = 5'b00100;
            mazePkg::Stop:      stateField = 5'b11100;
            mazePkg::Back:      stateField = 5'b01010;
            mazePkg::Error:     stateField = 5'b11111;
            default:            stateField = 5'b00000;
        endcase
    end

    // Middle lamps hint at the direction of travel
    always_comb begin
        case (state)
            mazePkg::Count:       activity = timers.countFlash ? 6'b000000 : 6'b111111;
            mazePkg::Straight:    activity = 6'b001100;
            mazePkg::LittleLeft:  activity = 6'b011000;
            mazePkg::LittleRight: activity = 6'b000110;
            mazePkg::TurnLeft:    activity = 6'b110000;
            mazePkg::TurnRight:   activity = 6'b000011;
            mazePkg::Stop:        activity = 6'b111111;
            mazePkg::Back:        activity = timers.backFlash ? 6'b000000 : 6'b111111;
            default:              activity = 6'b000000;
        endcase
    end

    // Obstacle lights everything
    assign led = obstacleNear ? '1 : {stateField, 1'b0, activity, 1'b0, road};

endmodule

// ==== source/mazeRobot.sv ====
`timescale 1ns/10ps

module mazeRobot (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  mazePkg::roadCode_t road,
    input  mazePkg::distance_t distance,
    output mazePkg::navState_t driveState,
    output mazePkg::ledWord_t  led
);

    mazePkg::checkpoints_t checkpoints;
    mazePkg::timerStatus_t timers;
    logic                  turnDone;
    logic                  obstacleNear;
    logic                  startDone;

    // The FSM state doubles as the motor stage command
    navFsm navFsm_i (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .road        (road),
        .distance    (distance),
        .checkpoints (checkpoints),
        .turnDone    (turnDone),
        .timers      (timers),
        .state       (driveState),
        .obstacleNear(obstacleNear),
        .startDone   (startDone)
    );

    checkpointTracker checkpointTracker_i (
        .clk        (clk),
        .rst        (rst),
        .state      (driveState),
        .road       (road),
        .startDone  (startDone),
        .checkpoints(checkpoints)
    );

    phaseTimer phaseTimer_i (
        .clk   (clk),
        .rst   (rst),
        .state (driveState),
        .timers(timers)
    );

    turnCounter turnCounter_i (
        .clk        (clk),
        .rst        (rst),
        .state      (driveState),
        .road       (road),
        .cpRightExit(checkpoints.cpRightExit),
        .turnDone   (turnDone),
        .crossings  ()
    );

    statusLeds statusLeds_i (
        .state       (driveState),
        .road        (road),
        .obstacleNear(obstacleNear),
        .timers      (timers),
        .led         (led)
    );

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rst
);

    localparam int halfPeriod = 50;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Reset covers the first four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== tests/mazeRobotTb.sv ====
`timescale 1ns/10ps

module mazeRobotTb;

    localparam int periodNs     = 100;
    localparam int testCycles   = 280;
    localparam int marginCycles = 100;

    // Reference model state, advanced once per rising edge
    typedef struct packed {
        mazePkg::navState_t    state;
        mazePkg::navState_t    stored;
        logic                  pop;
        mazePkg::checkpoints_t cp;
        logic [7:0]            crossings;
        logic                  fullPrev;
        logic [15:0]           dwell;
    } modelState_t;

    logic               clk;
    logic               rst;
    logic               enable;
    mazePkg::roadCode_t road;
    mazePkg::distance_t distance;
    mazePkg::navState_t driveState;
    mazePkg::ledWord_t  led;
    modelState_t        model;
    integer             seed;
    mazePkg::roadCode_t followCodes [6];

    clockGen clockGen_i (
        .clk(clk),
        .rst(rst)
    );

    mazeRobot mazeRobot_i (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .road      (road),
        .distance  (distance),
        .driveState(driveState),
        .led       (led)
    );

    function automatic logic updateFlag(input logic flag, input logic inGroup,
                                        input logic cond);
        if (inGroup && cond) begin
            return 1'b1;
        end
        return inGroup ? flag : 1'b0;
    endfunction

    function automatic modelState_t stepModel(input modelState_t m, input logic en,
                                              input mazePkg::roadCode_t r,
                                              input mazePkg::distance_t d);
        modelState_t        n;
        mazePkg::navState_t ns;
        logic               go;
        logic               countDone;
        logic               startDone;
        logic               turnDone;
        logic               inStraight;
        logic               fullNow;
        n          = m;
        ns         = m.state;
        go         = en && (d >= mazePkg::obstacleLimit);
        countDone  = (m.state == mazePkg::Count)
                     && (m.dwell == mazePkg::countSteps * mazePkg::countStepTicks - 1);
        startDone  = go && countDone;
        turnDone   = m.crossings >= mazePkg::rightCrossings;
        inStraight = m.state inside {mazePkg::Straight, mazePkg::LittleLeft,
                                     mazePkg::LittleRight};
        fullNow    = (m.state == mazePkg::TurnRight) && (r == mazePkg::roadFull);
        if (!en) begin
            ns = mazePkg::Idle;
        end else if (!go) begin
            ns = mazePkg::Finish;
        end else if (m.state == mazePkg::Idle) begin
            ns = mazePkg::Start;
        end else if (m.state == mazePkg::Start && r == mazePkg::roadStraight) begin
            ns = mazePkg::Count;
        end else if (countDone) begin
            ns = mazePkg::Straight;
        end else if (inStraight) begin
            if (r == mazePkg::roadNone) begin
                ns       = mazePkg::Stop;
                n.stored = mazePkg::Back;
            end else if (r == mazePkg::roadFull) begin
                ns = m.cp.cpStraight ? mazePkg::Choose : mazePkg::Straight;
            end else if (r inside {mazePkg::roadRight, mazePkg::roadRightSlight}) begin
                ns = mazePkg::LittleRight;
            end else if (r inside {mazePkg::roadLeft, mazePkg::roadLeftSlight}) begin
                ns = mazePkg::LittleLeft;
            end else begin
                ns = mazePkg::Straight;
            end
        end else if (m.state == mazePkg::Choose) begin
            if (r == mazePkg::roadSplit) begin
                ns       = mazePkg::Stop;
                n.stored = mazePkg::TurnLeft;
            end else if (r == mazePkg::roadFull && m.cp.cpChoose) begin
                ns = mazePkg::Straight;
            end
        end else if (m.state == mazePkg::TurnLeft) begin
            if (r == mazePkg::roadSplit && m.cp.cpLeftSplit) begin
                ns       = mazePkg::Stop;
                n.stored = mazePkg::TurnRight;
            end else if (r == mazePkg::roadFull && m.cp.cpLeftExit) begin
                ns       = mazePkg::Stop;
                n.stored = mazePkg::Straight;
            end
        end else if (m.state == mazePkg::TurnRight) begin
            if (r == mazePkg::roadSplit && turnDone) begin
                ns = mazePkg::Error;
            end else if (r == mazePkg::roadFull && m.cp.cpRightExit && turnDone) begin
                ns       = mazePkg::Stop;
                n.stored = mazePkg::Straight;
            end
        end else if (m.state == mazePkg::Back && r == mazePkg::roadFull) begin
            ns       = mazePkg::Stop;
            n.stored = m.pop ? mazePkg::TurnRight : mazePkg::TurnLeft;
            n.pop    = 1'b1;
        end else if (m.state == mazePkg::Stop && m.dwell == mazePkg::stopTicks - 1) begin
            ns = m.stored;
        end
        n.cp.cpChoose    = updateFlag(m.cp.cpChoose, m.state == mazePkg::Choose,
                                      r != mazePkg::roadFull);
        n.cp.cpStraight  = startDone || updateFlag(m.cp.cpStraight, inStraight,
                                                   r != mazePkg::roadFull);
        n.cp.cpLeftExit  = updateFlag(m.cp.cpLeftExit, m.state == mazePkg::TurnLeft,
                                      r != mazePkg::roadFull);
        n.cp.cpLeftSplit = updateFlag(m.cp.cpLeftSplit, m.state == mazePkg::TurnLeft,
                                      r != mazePkg::roadSplit);
        n.cp.cpRightExit = updateFlag(m.cp.cpRightExit, m.state == mazePkg::TurnRight,
                                      r != mazePkg::roadFull);
        // Only rising edges of the full line count, and only once the turn is armed
        if (m.state != mazePkg::TurnRight) begin
            n.crossings = '0;
        end else if (m.cp.cpRightExit && fullNow && !m.fullPrev) begin
            n.crossings = m.crossings + 1'b1;
        end
        n.fullPrev = fullNow;
        n.dwell    = (ns == m.state) ? m.dwell + 1'b1 : '0;
        n.state    = ns;
        return n;
    endfunction

    function automatic mazePkg::ledWord_t expectedLed(input modelState_t m,
                                                      input mazePkg::roadCode_t r,
                                                      input mazePkg::distance_t d);
        logic [4:0] field;
        logic [5:0] act;
        logic [2:0] lamp;
        logic       flashOff;
        if (d < mazePkg::obstacleLimit) begin
            return '1;
        end
        flashOff = ((m.dwell / mazePkg::flashTicks) % 2) == 1;
        case ((m.dwell / mazePkg::lampTicks) % 3)
            0:       lamp = 3'b001;
            1:       lamp = 3'b010;
            default: lamp = 3'b100;
        endcase
        case (m.state)
            mazePkg::Start:     field = 5'b00001;
            mazePkg::Count:     field = 5'b00010;
            mazePkg::Straight:  field = 5'b01000;
            mazePkg::Choose:    field = {lamp, 2'b00};
            mazePkg::TurnLeft:  field = 5'b10000;
            mazePkg::TurnRight: field = 5'b00100;
            mazePkg::Stop:      field = 5'b11100;
            mazePkg::Back:      field = 5'b01010;
            mazePkg::Error:     field = 5'b11111;
            default:            field = 5'b00000;
        endcase
        case (m.state)
            mazePkg::Count, mazePkg::Back: act = flashOff ? 6'b000000 : 6'b111111;
            mazePkg::Straight:             act = 6'b001100;
            mazePkg::LittleLeft:           act = 6'b011000;
            mazePkg::LittleRight:          act = 6'b000110;
            mazePkg::TurnLeft:             act = 6'b110000;
            mazePkg::TurnRight:            act = 6'b000011;
            mazePkg::Stop:                 act = 6'b111111;
            default:                       act = 6'b000000;
        endcase
        return {field, 1'b0, act, 1'b0, r};
    endfunction

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t signal=%s actual=0x%0h expected=0x%0h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic waitForState(input mazePkg::navState_t s, input int limit);
        int n;
        n = 0;
        while (driveState != s) begin
            if (n == limit) begin
                $display("driveState did not reach %s within %0d cycles", s.name(), limit);
                $display("Simulation failed");
                $fatal(1, "State wait timed out");
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    // Checks how long the DUT dwells in a state and where it goes next
    task automatic measureStay(input mazePkg::navState_t s, input int expected,
                               input mazePkg::navState_t after);
        int n;
        n = 0;
        waitForState(s, 4);
        while (driveState == s && n <= expected) begin
            @(negedge clk);
            n++;
        end
        compareValue($sformatf("cycles in %s", s.name()), n, expected);
        compareValue("driveState", driveState, after);
    endtask

    task automatic holdRoad(input mazePkg::roadCode_t r, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            road = r;
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model <= '0;
        end else begin
            model <= stepModel(model, enable, road, distance);
        end
    end

    // Outputs settle well before the next falling edge
    always begin
        @(posedge clk);
        #20;
        if (!rst) begin
            compareValue("driveState", driveState, model.state);
            compareValue("led", led, expectedLed(model, road, distance));
        end
    end

    initial begin
        #((testCycles + marginCycles) * periodNs);
        $display("Timeout after %0d cycles, the test sequence never finished",
                 testCycles + marginCycles);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int idx;
        seed        = 32'hd99a92a3;
        enable      = 1'b0;
        road        = mazePkg::roadStraight;
        distance    = 20'd100;
        followCodes = '{mazePkg::roadStraight, mazePkg::roadRight, mazePkg::roadRightSlight,
                        mazePkg::roadLeft, mazePkg::roadLeftSlight, mazePkg::roadSplit};
        wait (!rst);

        // Disabled robot stays in Idle
        repeat (12) begin
            @(negedge clk);
            road = mazePkg::roadCode_t'($random(seed));
        end

        // Start and countdown
        @(negedge clk);
        enable = 1'b1;
        road   = mazePkg::roadStraight;
        measureStay(mazePkg::Count, mazePkg::countSteps * mazePkg::countStepTicks,
                    mazePkg::Straight);

        // Line following without junctions or gaps
        repeat (30) begin
            @(negedge clk);
            idx  = $unsigned($random(seed)) % 6;
            road = followCodes[idx];
        end

        // Lost line, back up, first dead end tries left
        holdRoad(mazePkg::roadNone, 1);
        measureStay(mazePkg::Stop, mazePkg::stopTicks, mazePkg::Back);
        holdRoad(mazePkg::roadStraight, 10);
        holdRoad(mazePkg::roadFull, 1);
        measureStay(mazePkg::Stop, mazePkg::stopTicks, mazePkg::TurnLeft);
        holdRoad(mazePkg::roadStraight, 3);
        holdRoad(mazePkg::roadFull, 1);
        measureStay(mazePkg::Stop, mazePkg::stopTicks, mazePkg::Straight);

        // Junction with lamp rotation, then a left turn ending on a split
        holdRoad(mazePkg::roadStraight, 3);
        holdRoad(mazePkg::roadFull, 1);
        waitForState(mazePkg::Choose, 3);
        holdRoad(mazePkg::roadStraight, 20);
        holdRoad(mazePkg::roadSplit, 1);
        measureStay(mazePkg::Stop, mazePkg::stopTicks, mazePkg::TurnLeft);
        holdRoad(mazePkg::roadStraight, 3);
        holdRoad(mazePkg::roadSplit, 1);
        measureStay(mazePkg::Stop, mazePkg::stopTicks, mazePkg::TurnRight);

        // Right turn needs two full-line crossings
        holdRoad(mazePkg::roadStraight, 2);
        holdRoad(mazePkg::roadFull, 1);
        holdRoad(mazePkg::roadStraight, 1);
        holdRoad(mazePkg::roadFull, 1);
        measureStay(mazePkg::Stop, mazePkg::stopTicks, mazePkg::Straight);

        // Second dead end goes right, then a split ends in Error
        holdRoad(mazePkg::roadStraight, 2);
        holdRoad(mazePkg::roadNone, 1);
        measureStay(mazePkg::Stop, mazePkg::stopTicks, mazePkg::Back);
        holdRoad(mazePkg::roadStraight, 3);
        holdRoad(mazePkg::roadFull, 1);
        measureStay(mazePkg::Stop, mazePkg::stopTicks, mazePkg::TurnRight);
        holdRoad(mazePkg::roadStraight, 2);
        holdRoad(mazePkg::roadFull, 1);
        holdRoad(mazePkg::roadStraight, 1);
        holdRoad(mazePkg::roadFull, 1);
        holdRoad(mazePkg::roadStraight, 1);
        holdRoad(mazePkg::roadSplit, 1);
        waitForState(mazePkg::Error, 3);
        holdRoad(mazePkg::roadStraight, 4);
        compareValue("driveState", driveState, mazePkg::Error);

        // Obstacle lights the LEDs at once and finishes on the next edge
        @(negedge clk);
        distance = 20'd1;
        #1;
        compareValue("led", led, 16'hffff);
        @(posedge clk);
        #20;
        compareValue("driveState", driveState, mazePkg::Finish);
        holdRoad(mazePkg::roadStraight, 3);
        distance = 20'd100;
        holdRoad(mazePkg::roadLeft, 3);
        compareValue("driveState", driveState, mazePkg::Finish);

        // Dropping enable returns to Idle
        @(negedge clk);
        enable = 1'b0;
        @(posedge clk);
        #20;
        compareValue("driveState", driveState, mazePkg::Idle);
        holdRoad(mazePkg::roadRight, 3);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== mazeRobot.f ====
source/mazePkg.sv
source/navFsm.sv
source/checkpointTracker.sv
source/phaseTimer.sv
source/turnCounter.sv
source/statusLeds.sv
source/mazeRobot.sv
tests/clockGen.sv
tests/mazeRobotTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the maze robot testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mazeRobotTb \
    -f mazeRobot.f -o simMazeRobot > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/simMazeRobot > sim.log 2>&1
grep -qx "Simulation passed" sim.log && echo "Test passed" \
    || { echo "Test failed, see sim.log"; exit 1; }
